// File: hw/rvfi_mon_pkg.sv
// Shared types for the retirement trace monitor; every monitor file refers to them by scoped name
package rvfi_mon_pkg;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Debug entry cause with the same encoding as the core's dcsr.cause field
  typedef enum logic [2:0] {
    NONE    = 3'd0,
    EBREAK  = 3'd1,
    TRIGGER = 3'd2,
    HALTREQ = 3'd3,
    STEP    = 3'd4
  } dbg_cause_e;

  // Violation codes; code k owns bit k of a violation vector
  typedef enum logic [2:0] {
    V_NONE               = 3'd0,
    V_TRAP_NO_INTR       = 3'd1,
    V_MCAUSE_MISMATCH    = 3'd2,
    V_DBG_CAUSE_MISMATCH = 3'd3,
    V_STEP_CAUSE_BAD     = 3'd4,
    V_DBG_NO_ACK         = 3'd5,
    V_IRQ_NOT_CAPTURED   = 3'd6,
    V_DBG_NOT_CAPTURED   = 3'd7
  } viol_e;

  // One flag per violation code where bit 0 stays unused since it maps to V_NONE
  localparam int NUM_VIOL = 8;

  typedef logic [NUM_VIOL-1:0] viol_vec_t;

  ////////////////////////////////////////////////////////////
  // Trace traffic
  ////////////////////////////////////////////////////////////

  // Trap report attached to a retiring instruction
  typedef struct packed {
    logic       exception;
    logic       debug;
    dbg_cause_e debug_cause;
    logic [5:0] exception_cause;
  } trap_t;

  // One retirement as seen on the trace port, with the CSR bits the checks need
  typedef struct packed {
    logic       valid;
    logic       intr;
    dbg_cause_e dbg;
    trap_t      trap;
    logic [5:0] mcause_lo;
    logic       dcsr_step;   // dcsr bit 2
    logic       debug_mode;
  } retire_t;

  // Acknowledge strobes and levels from the core controller
  typedef struct packed {
    logic       irq_ack;
    logic       dbg_ack;
    dbg_cause_e dbg_cause;
    logic       ebreak_in_wb;
  } ack_t;

  // Trap information latched by the trace logic at the fetch stage
  typedef struct packed {
    logic       intr;
    dbg_cause_e dbg_cause;
  } capture_t;

endpackage

// File: hw/trap_follow_check.sv
// Checks each retirement's trap report against the next valid retirement; used inside the monitor top
`timescale 1ns/1ps

module trap_follow_check (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  rvfi_mon_pkg::retire_t   retire_i,
  output rvfi_mon_pkg::viol_vec_t viol_o
);

  ////////////////////////////////////////////////////////////
  // State carried from the previous valid retirement
  ////////////////////////////////////////////////////////////

  // Trap report of the last valid retirement including empty reports
  rvfi_mon_pkg::trap_t trap_q;

  // High when the last valid retirement was neither single stepping nor in debug mode
  logic armed_q;

  // Single step or debug mode suspends the intr and mcause rules
  logic no_debug;

  rvfi_mon_pkg::viol_vec_t viol_d;
  rvfi_mon_pkg::viol_vec_t viol_q;

  assign no_debug = !(retire_i.dcsr_step || retire_i.debug_mode);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_q  <= '0;
      armed_q <= 1'b0;
    end else if (retire_i.valid) begin
      // Every valid retirement replaces the stored report
      trap_q  <= retire_i.trap;
      armed_q <= no_debug;
    end
  end

  ////////////////////////////////////////////////////////////
  // Rule evaluation
  ////////////////////////////////////////////////////////////

  always_comb begin
    viol_d = '0;

    if (retire_i.valid) begin
      // An exception must lead into the handler with intr set
      // and mcause must carry the reported exception code
      if (trap_q.exception && armed_q) begin
        if (!retire_i.intr) begin
          viol_d[rvfi_mon_pkg::V_TRAP_NO_INTR] = 1'b1;
        end
        if (retire_i.mcause_lo != trap_q.exception_cause) begin
          viol_d[rvfi_mon_pkg::V_MCAUSE_MISMATCH] = 1'b1;
        end
      end

      // A debug trap must be followed by debug entry with the same cause
      if (trap_q.debug && (retire_i.dbg != trap_q.debug_cause)) begin
        viol_d[rvfi_mon_pkg::V_DBG_CAUSE_MISMATCH] = 1'b1;
      end

      // Exception and debug together only happen when an exception
      // hits during single step, so the cause has to be STEP
      if (retire_i.trap.exception && retire_i.trap.debug &&
          (retire_i.trap.debug_cause != rvfi_mon_pkg::STEP)) begin
        viol_d[rvfi_mon_pkg::V_STEP_CAUSE_BAD] = 1'b1;
      end
    end
  end

  // Vector shows the rules hit by the inputs of the previous edge only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      viol_q <= '0;
    end else begin
      viol_q <= viol_d;
    end
  end

  assign viol_o = viol_q;

endmodule

// File: hw/ack_capture_check.sv
// Checks irq and debug acknowledges against fetch capture and debug retirements; used inside the monitor top
`timescale 1ns/1ps

module ack_capture_check #(
  parameter bit IRQ_CHECK_EN = 1'b1
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  rvfi_mon_pkg::retire_t   retire_i,
  input  rvfi_mon_pkg::ack_t      ack_i,
  input  rvfi_mon_pkg::capture_t  capture_i,
  output rvfi_mon_pkg::viol_vec_t viol_o
);

  ////////////////////////////////////////////////////////////
  // Acknowledges from the previous cycle
  ////////////////////////////////////////////////////////////

  logic irq_ack_q;
  logic dbg_ack_q;

  // EBREAK while already in debug mode does not show up in the controller's cause
  rvfi_mon_pkg::dbg_cause_e exp_cause;
  rvfi_mon_pkg::dbg_cause_e exp_cause_q;

  // Debug entry seen on the trace port
  logic dbg_retire;

  // Outstanding debug acknowledges not yet matched by a debug retirement
  logic [1:0] ack_cnt_q;

  rvfi_mon_pkg::viol_vec_t viol_d;
  rvfi_mon_pkg::viol_vec_t viol_q;

  assign exp_cause  = (retire_i.debug_mode && ack_i.ebreak_in_wb) ? rvfi_mon_pkg::EBREAK :
                      ack_i.dbg_cause;
  assign dbg_retire = retire_i.valid && (retire_i.dbg != rvfi_mon_pkg::NONE);

  // Expected capture cause travels with the debug acknowledge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_ack_q   <= 1'b0;
      dbg_ack_q   <= 1'b0;
      exp_cause_q <= rvfi_mon_pkg::NONE;
    end else begin
      irq_ack_q   <= ack_i.irq_ack;
      dbg_ack_q   <= ack_i.dbg_ack;
      exp_cause_q <= exp_cause;
    end
  end

  // Counter holds at its ends instead of wrapping
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_cnt_q <= 2'd0;
    end else if (ack_i.dbg_ack && !dbg_retire && (ack_cnt_q != 2'd3)) begin
      ack_cnt_q <= ack_cnt_q + 2'd1;
    end else if (dbg_retire && !ack_i.dbg_ack && (ack_cnt_q != 2'd0)) begin
      ack_cnt_q <= ack_cnt_q - 2'd1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Rule evaluation
  ////////////////////////////////////////////////////////////

  always_comb begin
    viol_d = '0;
    // Rule is dropped for a vectored interrupt controller
    if (IRQ_CHECK_EN && irq_ack_q && !capture_i.intr) begin
      viol_d[rvfi_mon_pkg::V_IRQ_NOT_CAPTURED] = 1'b1;
    end
    if (dbg_ack_q && (capture_i.dbg_cause != exp_cause_q)) begin
      viol_d[rvfi_mon_pkg::V_DBG_NOT_CAPTURED] = 1'b1;
    end
    // An acknowledge in the same cycle also covers the retirement
    if (dbg_retire && (ack_cnt_q == 2'd0) && !ack_i.dbg_ack) begin
      viol_d[rvfi_mon_pkg::V_DBG_NO_ACK] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      viol_q <= '0;
    end else begin
      viol_q <= viol_d;
    end
  end

  assign viol_o = viol_q;

endmodule

// File: hw/violation_log.sv
// Collects both checkers' violation vectors into sticky flags, a count and the first code
`timescale 1ns/1ps

module violation_log #(
  parameter int CNT_W = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  rvfi_mon_pkg::viol_vec_t trap_viol_i,
  input  rvfi_mon_pkg::viol_vec_t ack_viol_i,
  output rvfi_mon_pkg::viol_vec_t flags_o,
  output logic [CNT_W-1:0]        err_cnt_o,
  output rvfi_mon_pkg::viol_e     first_o
);

  // Room for the population of both vectors together
  localparam int POP_W = $clog2(2 * rvfi_mon_pkg::NUM_VIOL + 1);
  localparam int SUM_W = ((CNT_W > POP_W) ? CNT_W : POP_W) + 1;

  rvfi_mon_pkg::viol_vec_t trap_hits;
  rvfi_mon_pkg::viol_vec_t ack_hits;
  rvfi_mon_pkg::viol_vec_t any_hits;
  logic [POP_W-1:0]        pop;
  logic [SUM_W-1:0]        sum;
  logic [CNT_W-1:0]        cnt_next;
  rvfi_mon_pkg::viol_e     low_code;

  // Bit 0 stands for V_NONE and never counts
  assign trap_hits = trap_viol_i & ~rvfi_mon_pkg::viol_vec_t'(1);
  assign ack_hits  = ack_viol_i & ~rvfi_mon_pkg::viol_vec_t'(1);
  assign any_hits  = trap_hits | ack_hits;

  always_comb begin
    pop      = '0;
    low_code = rvfi_mon_pkg::V_NONE;
    for (int k = 0; k < rvfi_mon_pkg::NUM_VIOL; k++) begin
      pop = pop + POP_W'(trap_hits[k]) + POP_W'(ack_hits[k]);
    end
    // Walk downwards so the lowest set code wins
    for (int k = rvfi_mon_pkg::NUM_VIOL - 1; k > 0; k--) begin
      if (any_hits[k]) begin
        low_code = rvfi_mon_pkg::viol_e'(3'(k));
      end
    end
    sum      = SUM_W'(err_cnt_o) + SUM_W'(pop);
    cnt_next = (sum > SUM_W'({CNT_W{1'b1}})) ? {CNT_W{1'b1}} : sum[CNT_W-1:0];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flags_o   <= '0;
      err_cnt_o <= '0;
      first_o   <= rvfi_mon_pkg::V_NONE;
    end else if (clear_i) begin
      // Bits arriving with the clear are dropped
      flags_o   <= '0;
      err_cnt_o <= '0;
      first_o   <= rvfi_mon_pkg::V_NONE;
    end else begin
      flags_o   <= flags_o | any_hits;
      err_cnt_o <= cnt_next;
      if ((first_o == rvfi_mon_pkg::V_NONE) && (|any_hits)) begin
        first_o <= low_code;
      end
    end
  end

endmodule

// File: hw/rvfi_monitor_top.sv
// Top level of the retirement trace monitor; drive the trace inputs and read the violation log
`timescale 1ns/1ps

module rvfi_monitor_top #(
  parameter bit IRQ_CHECK_EN = 1'b1,
  parameter int CNT_W        = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  rvfi_mon_pkg::retire_t   retire_i,
  input  rvfi_mon_pkg::ack_t      ack_i,
  input  rvfi_mon_pkg::capture_t  capture_i,
  input  logic                    clear_i,
  output rvfi_mon_pkg::viol_vec_t flags_o,
  output logic [CNT_W-1:0]        err_cnt_o,
  output rvfi_mon_pkg::viol_e     first_o
);

  ////////////////////////////////////////////////////////////
  // Checker outputs
  ////////////////////////////////////////////////////////////

  rvfi_mon_pkg::viol_vec_t trap_viol;
  rvfi_mon_pkg::viol_vec_t ack_viol;

  // Rules linking one retirement to the next
  trap_follow_check i_trap_follow_check (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .retire_i (retire_i),
    .viol_o   (trap_viol)
  );

  // Rules linking acknowledges to fetch capture and debug entry
  ack_capture_check #(
    .IRQ_CHECK_EN (IRQ_CHECK_EN)
  ) i_ack_capture_check (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .retire_i  (retire_i),
    .ack_i     (ack_i),
    .capture_i (capture_i),
    .viol_o    (ack_viol)
  );

  violation_log #(
    .CNT_W (CNT_W)
  ) i_violation_log (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .trap_viol_i (trap_viol),
    .ack_viol_i  (ack_viol),
    .flags_o     (flags_o),
    .err_cnt_o   (err_cnt_o),
    .first_o     (first_o)
  );

endmodule

// File: sim/tb_rvfi_monitor.sv
// Self-checking testbench for the retirement trace monitor; replays sim/rvfi_cases.txt cycle by cycle
`timescale 1ns/1ps

module tb_rvfi_monitor;

  localparam int CLK_PERIOD = 40;

  logic                    clk_i;
  logic                    rst_ni;
  rvfi_mon_pkg::retire_t   retire_i;
  rvfi_mon_pkg::ack_t      ack_i;
  rvfi_mon_pkg::capture_t  capture_i;
  logic                    clear_i;
  rvfi_mon_pkg::viol_vec_t flags_o;
  logic [7:0]              err_cnt_o;
  rvfi_mon_pkg::viol_e     first_o;

  // Parsed case file with one kind per line plus per-kind queues in file order
  logic [7:0]              kinds[$];
  rvfi_mon_pkg::retire_t   c_ret[$];
  rvfi_mon_pkg::ack_t      c_ack[$];
  rvfi_mon_pkg::capture_t  c_cap[$];
  logic [255:0]            e_name[$];
  rvfi_mon_pkg::viol_vec_t e_flags[$];
  logic [7:0]              e_cnt[$];
  rvfi_mon_pkg::viol_e     e_first[$];

  int   seed = 11649;
  int   mismatches = 0;
  int   other_errs = 0;
  int   n_checks = 0;
  logic loaded = 1'b0;

  rvfi_monitor_top i_dut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .retire_i  (retire_i),
    .ack_i     (ack_i),
    .capture_i (capture_i),
    .clear_i   (clear_i),
    .flags_o   (flags_o),
    .err_cnt_o (err_cnt_o),
    .first_o   (first_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Case file parsing
  ////////////////////////////////////////////////////////////

  task automatic read_cases(input int fd);
    logic [7:0]         kind;
    logic [255:0]       name;
    logic [8*256-1:0]   rest;
    int                 f [16];
    int                 code;
    int                 fl;
    int                 cn;
    int                 fi;
    while ($fscanf(fd, " %c", kind) == 1) begin
      if (kind == "#") begin
        code = $fgets(rest, fd);
      end else if (kind == "C") begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                       f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
        if (code != 16) begin
          other_errs++;
          $display("Case file has a C line with %0d readable fields instead of 16", code);
          code = $fgets(rest, fd);
        end else begin
          // Field order follows the struct layout with the most significant field first
          kinds.push_back("C");
          c_ret.push_back({f[0][0], f[1][0], f[2][2:0], f[3][0], f[4][0], f[5][2:0],
                           f[6][5:0], f[7][5:0], f[8][0], f[9][0]});
          c_ack.push_back({f[10][0], f[11][0], f[12][2:0], f[13][0]});
          c_cap.push_back({f[14][0], f[15][2:0]});
        end
      end else if (kind == "E") begin
        code = $fscanf(fd, "%s %h %d %d", name, fl, cn, fi);
        if (code != 4) begin
          other_errs++;
          $display("Case file has an E line that could not be read");
          code = $fgets(rest, fd);
        end else begin
          kinds.push_back("E");
          e_name.push_back(name);
          e_flags.push_back(fl[7:0]);
          e_cnt.push_back(cn[7:0]);
          e_first.push_back(rvfi_mon_pkg::viol_e'(fi[2:0]));
        end
      end else if (kind == "X") begin
        kinds.push_back("X");
      end else begin
        other_errs++;
        $display("Case file holds an unknown line kind %c", kind);
        code = $fgets(rest, fd);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////////////////////////

  // Idle means no retirement, no acknowledge and an interrupt-marked capture
  task automatic drive_idle(input logic clear);
    @(negedge clk_i);
    retire_i  = '0;
    ack_i     = '0;
    capture_i = '{intr: 1'b1, dbg_cause: rvfi_mon_pkg::NONE};
    clear_i   = clear;
  endtask

  // The capture cause is only compared after a debug acknowledge, so it may wander here
  task automatic drive_filler();
    int rnd;
    drive_idle(1'b0);
    rnd = $random(seed);
    capture_i.dbg_cause = rvfi_mon_pkg::dbg_cause_e'(rnd[2:0] % 3'd5);
  endtask

  task automatic drive_cycle(input int idx);
    @(negedge clk_i);
    retire_i  = c_ret[idx];
    ack_i     = c_ack[idx];
    capture_i = c_cap[idx];
    clear_i   = 1'b0;
  endtask

  // Two idle cycles let one-cycle-back rules reach the log outputs
  task automatic check_case(input int idx);
    int fill;
    drive_idle(1'b0);
    drive_idle(1'b0);
    @(negedge clk_i);
    n_checks++;
    assert (flags_o == e_flags[idx]) else begin
      mismatches++;
      $display("Mismatch in %0s flags: expected %h, actual %h", e_name[idx], e_flags[idx],
               flags_o);
    end
    assert (err_cnt_o == e_cnt[idx]) else begin
      mismatches++;
      $display("Mismatch in %0s count: expected %0d, actual %0d", e_name[idx], e_cnt[idx],
               err_cnt_o);
    end
    assert (first_o == e_first[idx]) else begin
      mismatches++;
      $display("Mismatch in %0s first code: expected %0d, actual %0d", e_name[idx],
               e_first[idx], first_o);
    end
    fill = $random(seed) & 1;
    repeat (fill) drive_filler();
  endtask

  initial begin
    int fd;
    int c_idx;
    int e_idx;
    retire_i  = '0;
    ack_i     = '0;
    capture_i = '{intr: 1'b1, dbg_cause: rvfi_mon_pkg::NONE};
    clear_i   = 1'b0;
    rst_ni    = 1'b0;
    fd = $fopen("sim/rvfi_cases.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("Cannot open the case file sim/rvfi_cases.txt");
    end else begin
      read_cases(fd);
      $fclose(fd);
    end
    loaded = 1'b1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    c_idx  = 0;
    e_idx  = 0;
    foreach (kinds[i]) begin
      if (kinds[i] == "C") begin
        drive_cycle(c_idx);
        c_idx++;
      end else if (kinds[i] == "E") begin
        check_case(e_idx);
        e_idx++;
      end else begin
        drive_idle(1'b1);
      end
    end
    drive_idle(1'b0);
    if (n_checks == 0) begin
      other_errs++;
      $display("No test case was found in the case file");
    end
    $display("Checks %0d, mismatches %0d, other errors %0d", n_checks, mismatches, other_errs);
    if ((mismatches + other_errs) == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Budget covers every stimulus cycle, the per-case idle and filler cycles and reset
  initial begin
    int limit;
    wait (loaded);
    limit = c_ret.size() + 4 * e_name.size() + 20;
    #(limit * CLK_PERIOD);
    $display("Watchdog expired after %0d clock periods without finishing the cases", limit);
    $display("Test failed");
    $finish;
  end

endmodule

// File: sim/rvfi_cases.txt
# Kinds: C = one stimulus cycle, E = name flags_hex count first_code, X = clear pulse
# C fields (hex): valid intr dbg exc dbg_trap trap_cause exc_cause mcause step dmode irq_ack dbg_ack ack_cause ebreak cap_intr cap_cause
C 1 0 0 1 0 0 05 00 0 0 0 0 0 0 1 0
C 1 1 0 0 0 0 00 05 0 0 0 0 0 0 1 0
E trap_ok 00 0 0
C 1 0 0 1 0 0 05 00 0 0 0 0 0 0 1 0
C 1 0 0 0 0 0 00 07 0 0 0 0 0 0 1 0
E trap_bad 06 2 1
X
C 1 0 0 0 1 2 00 00 0 0 0 0 0 0 1 0
C 1 0 3 0 0 0 00 00 0 0 0 1 3 0 1 0
C 0 0 0 0 0 0 00 00 0 0 0 0 0 0 1 3
E dbg_mismatch 08 1 3
X
C 1 0 0 1 1 2 03 00 0 0 0 0 0 0 1 0
C 1 1 2 0 0 0 00 03 0 0 0 1 2 0 1 0
C 0 0 0 0 0 0 00 00 0 0 0 0 0 0 1 2
E step_cause 10 1 4
X
C 1 0 0 1 0 0 05 00 1 0 0 0 0 0 1 0
C 1 0 0 0 0 0 00 00 0 0 0 0 0 0 1 0
E step_exempt 00 0 0
C 0 0 0 0 0 0 00 00 0 0 1 0 0 0 1 0
C 0 0 0 0 0 0 00 00 0 0 0 0 0 0 0 0
E irq_capture 40 1 6
X
C 0 0 0 0 0 0 00 00 0 1 0 1 3 1 1 0
C 0 0 0 0 0 0 00 00 0 0 0 0 0 0 1 3
E dbg_capture 80 1 7
X
C 1 0 3 0 0 0 00 00 0 0 0 0 0 0 1 0
E dbg_after_ack 00 0 0
C 1 0 3 0 0 0 00 00 0 0 0 0 0 0 1 0
E dbg_no_ack 20 1 5
X
E cleared 00 0 0
C 0 0 0 0 0 0 00 00 0 0 1 0 0 0 1 0
C 0 0 0 0 0 0 00 00 0 0 0 0 0 0 0 0
E accum_a 40 1 6
C 1 0 0 1 0 0 05 00 0 0 0 0 0 0 1 0
C 1 0 0 0 0 0 00 07 0 0 0 0 0 0 1 0
E accum_b 46 3 6

// File: all.f
hw/rvfi_mon_pkg.sv
hw/trap_follow_check.sv
hw/ack_capture_check.sv
hw/violation_log.sv
hw/rvfi_monitor_top.sv
sim/tb_rvfi_monitor.sv

// File: Makefile
LOG := sim.log

sim:
	verilator --binary --timing --assert -j 0 -f all.f --top-module tb_rvfi_monitor -Mdir obj_dir
	./obj_dir/Vtb_rvfi_monitor | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
